//--- list.f
+incdir+include
src/lcd_pkg.sv
src/lcd_axil_decode.sv
src/lcd_bus_exec.sv
src/lcd_result.sv
src/lcd_ctrl_top.sv
tests/tb_clk_gen.sv
tests/tb_lcd_ctrl.sv

//--- tests/tb_lcd_ctrl.sv
`timescale 1ns/1ns
`include "lcd_defs.svh"

module tb_lcd_ctrl
	import lcd_pkg::*;
();

	localparam int T          = `LCD_TICKS_PER_US;
	localparam int INIT_US    = 4 * `LCD_CMD_US + 2 * `LCD_GAP_US + `LCD_CLEAR_GAP_US
		+ `LCD_ENTRY_GAP_US;
	localparam int RUN_US     = `LCD_POWERUP_US + INIT_US + 12 * `LCD_CYCLE_US;
	localparam longint WATCHDOG_NS = 2 * RUN_US * T * 20; // twice the nominal run
	localparam int HS_LIMIT   = 16;
	localparam int POLL_LIMIT = 600;

	logic        clk;
	logic        arst_n;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [31:0] araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        e;
	logic        rs;
	logic        rw;
	logic [7:0]  lcd_data;
	logic [7:0]  lcd_rdata;

	logic [31:0] lfsr_state;
	logic [7:0]  rd_expect; // byte the panel handed back last
	logic [7:0]  xfer_exp;
	logic        e_prev;
	lcd_reg_u    edge_q[$]; // rs, rw and data seen at each e fall

	tb_clk_gen u_clk_gen (.clk(clk), .arst_n(arst_n));

	lcd_ctrl_top u_lcd_ctrl_top (
		.clk(clk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data), .lcd_rdata(lcd_rdata)
	);

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic lcd_reg_u make_cfg(input logic [6:0] bits); // n f d c b id s
		lcd_reg_u r;
		r = '0;
		{r.cfg.n, r.cfg.f, r.cfg.d, r.cfg.c, r.cfg.b, r.cfg.id, r.cfg.s} = bits;
		return r;
	endfunction

	function automatic lcd_reg_u make_cmd(input logic rs_b, input logic rw_b,
			input logic [7:0] data);
		lcd_reg_u r;
		r = '0;
		r.cmd.rs   = rs_b;
		r.cmd.rw   = rw_b;
		r.cmd.data = data;
		return r;
	endfunction

	function automatic lcd_status_t make_status(input logic busy_b, input logic done_b,
			input logic valid_b, input logic [7:0] byte_b, input logic [7:0] count);
		lcd_status_t s;
		s            = '0;
		s.busy       = busy_b;
		s.init_done  = done_b;
		s.rd_valid   = valid_b;
		s.rd_byte    = byte_b;
		s.xfer_count = count;
		return s;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	task automatic check_status(input string name, input lcd_status_t got,
			input lcd_status_t exp);
		if (got.busy !== exp.busy || got.init_done !== exp.init_done ||
			got.rd_valid !== exp.rd_valid || got.xfer_count !== exp.xfer_count ||
			(exp.rd_valid && got.rd_byte !== exp.rd_byte)) // byte only means something while valid
			fail_now($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_reg(input string name, input lcd_reg_u got, input lcd_reg_u exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic check_resp(input string name, input logic [1:0] got,
			input logic [1:0] exp);
		if (got !== exp)
			fail_now($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			fail_now($sformatf("mismatch at %0t ns: %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	task automatic next_rdata();
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			rd_expect  = {rd_expect[6:0], lfsr_state[0]}; // one step per bit
		end
		lcd_rdata = rd_expect;
	endtask

	// panel model, sampled on the falling clock where the pins are settled
	always @(negedge clk) begin : responder
		lcd_reg_u rec;
		if (e === 1'b1 && e_prev === 1'b0 && rw === 1'b1)
			next_rdata(); // present the byte well before e drops
		if (e === 1'b0 && e_prev === 1'b1) begin
			rec = make_cmd(rs, rw, lcd_data);
			edge_q.push_back(rec);
		end
		e_prev = e;
	end

	task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
			input int stall, output logic [1:0] resp);
		int n;
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		n = 0;
		while (!(awready && wready)) begin
			@(negedge clk);
			n++;
			if (n > HS_LIMIT)
				fail_now("write address and data were never accepted");
		end
		@(negedge clk); // taken on the rising edge just passed
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		while (!bvalid) begin
			@(negedge clk);
			n++;
			if (n > HS_LIMIT)
				fail_now("no write response arrived");
		end
		repeat (stall) begin
			@(negedge clk);
			if (!bvalid)
				fail_now("write response dropped while bready was low");
		end
		resp   = bresp;
		bready = 1'b1;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [31:0] addr, input int stall,
			output logic [31:0] data, output logic [1:0] resp);
		int n;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		n = 0;
		while (!arready) begin
			@(negedge clk);
			n++;
			if (n > HS_LIMIT)
				fail_now("read address was never accepted");
		end
		@(negedge clk);
		arvalid = 1'b0;
		n = 0;
		while (!rvalid) begin
			@(negedge clk);
			n++;
			if (n > HS_LIMIT)
				fail_now("no read data arrived");
		end
		repeat (stall) begin
			@(negedge clk);
			if (!rvalid)
				fail_now("read data dropped while rready was low");
		end
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic wait_idle(output lcd_status_t st);
		logic [31:0] data;
		logic [1:0]  resp;
		int          n;
		n = 0;
		do begin
			axi_read(`LCD_ADDR_STATUS, 0, data, resp);
			st = data;
			n++;
			if (n > POLL_LIMIT)
				fail_now("controller stayed busy for too long");
		end while (st.busy !== 1'b0);
	endtask

	task automatic expect_init(input lcd_reg_u cfg);
		logic [7:0] bytes [4];
		check_count("init edge count", edge_q.size(), 4);
		bytes[0] = {4'b0011, cfg.cfg.n, cfg.cfg.f, 2'b00}; // function set
		bytes[1] = {5'b00001, cfg.cfg.d, cfg.cfg.c, cfg.cfg.b};
		bytes[2] = 8'h01;
		bytes[3] = {6'b000001, cfg.cfg.id, cfg.cfg.s}; // entry mode
		foreach (bytes[i])
			check_reg("init edge", edge_q.pop_front(), make_cmd(1'b0, 1'b0, bytes[i]));
	endtask

	task automatic expect_cmd_edge(input lcd_reg_u cmd);
		check_count("command edge count", edge_q.size(), 1);
		check_reg("command edge", edge_q.pop_front(), cmd);
	endtask

	task automatic run_cmd(input lcd_reg_u cmd);
		logic [1:0]  resp;
		lcd_status_t st;
		axi_write(`LCD_ADDR_CMD, cmd, 0, resp);
		check_resp("bresp cmd", resp, `LCD_RESP_OKAY);
		wait_idle(st);
		xfer_exp++;
		check_status("status after cmd", st, make_status(0, 1, 0, 8'h00, xfer_exp));
		expect_cmd_edge(cmd);
	endtask

	task automatic powerup_reject_test();
		logic [31:0] data;
		logic [1:0]  resp;
		axi_write(`LCD_ADDR_CMD, make_cmd(1, 0, 8'h41), 0, resp);
		check_resp("bresp cmd in power-up", resp, `LCD_RESP_SLVERR);
		axi_write(`LCD_ADDR_CFG, make_cfg(7'b1011110), 0, resp);
		check_resp("bresp cfg in power-up", resp, `LCD_RESP_SLVERR);
		axi_read(`LCD_ADDR_STATUS, 0, data, resp);
		check_status("status in power-up", data, make_status(1, 0, 0, 8'h00, 8'h00));
		check_count("edges in power-up", edge_q.size(), 0);
	endtask

	task automatic init_sequence_test();
		lcd_reg_u    cfg;
		logic [1:0]  resp;
		lcd_status_t st;
		wait_idle(st);
		check_status("status waiting for cfg", st, make_status(0, 0, 0, 8'h00, 8'h00));
		cfg = make_cfg(7'b1011110); // two lines, display, cursor, blink, increment
		axi_write(`LCD_ADDR_CFG, cfg, 0, resp);
		check_resp("bresp cfg", resp, `LCD_RESP_OKAY);
		wait_idle(st);
		check_status("status after init", st, make_status(0, 1, 0, 8'h00, 8'h00));
		expect_init(cfg);
	endtask

	task automatic cmd_write_test();
		run_cmd(make_cmd(1, 0, 8'h41));
		run_cmd(make_cmd(0, 0, 8'h80)); // set ddram address
		run_cmd(make_cmd(1, 0, 8'h5a));
	endtask

	task automatic busy_reject_test();
		lcd_reg_u    cmd;
		logic [1:0]  resp;
		lcd_status_t st;
		cmd = make_cmd(1, 0, 8'h33);
		axi_write(`LCD_ADDR_CMD, cmd, 0, resp);
		check_resp("bresp first cmd", resp, `LCD_RESP_OKAY);
		axi_write(`LCD_ADDR_CMD, make_cmd(1, 0, 8'hcc), 0, resp);
		check_resp("bresp cmd while busy", resp, `LCD_RESP_SLVERR);
		wait_idle(st);
		xfer_exp++;
		check_status("status after reject", st, make_status(0, 1, 0, 8'h00, xfer_exp));
		expect_cmd_edge(cmd);
	endtask

	task automatic read_cycle_test();
		lcd_reg_u    cmd;
		logic [31:0] data;
		logic [1:0]  resp;
		lcd_status_t st;
		int          n;
		cmd = make_cmd(1, 1, 8'h00);
		axi_write(`LCD_ADDR_CMD, cmd, 0, resp);
		check_resp("bresp read cmd", resp, `LCD_RESP_OKAY);
		n = 0;
		while (edge_q.size() == 0) begin
			@(negedge clk);
			n++;
			if (n > `LCD_CYCLE_US * T)
				fail_now("enable never fell during the read cycle");
		end
		@(negedge clk);
		// e falls at 14T of a 50T cycle, so the cycle is still running here
		axi_read(`LCD_ADDR_STATUS, 0, data, resp);
		check_status("status after read", data, make_status(1, 1, 1, rd_expect, xfer_exp));
		wait_idle(st);
		xfer_exp++;
		check_status("status second read", st, make_status(0, 1, 0, 8'h00, xfer_exp));
		expect_cmd_edge(cmd);
	endtask

	task automatic backpressure_test();
		lcd_reg_u    cfg;
		logic [31:0] data;
		logic [1:0]  resp;
		lcd_status_t st;
		cfg = make_cfg(7'b0110101); // one line, 5x10 font, blink, shift
		axi_write(`LCD_ADDR_CFG, cfg, 4, resp);
		check_resp("bresp stalled cfg", resp, `LCD_RESP_OKAY);
		axi_read(`LCD_ADDR_CFG, 5, data, resp);
		check_resp("rresp stalled cfg", resp, `LCD_RESP_OKAY);
		check_reg("cfg readback", data, cfg);
		axi_read(32'h0000_000c, 0, data, resp);
		check_resp("rresp unknown addr", resp, `LCD_RESP_SLVERR);
		axi_write(32'h0000_000c, 32'h0, 0, resp);
		check_resp("bresp unknown addr", resp, `LCD_RESP_SLVERR);
		axi_write(`LCD_ADDR_STATUS, 32'hffff_ffff, 0, resp);
		check_resp("bresp status write", resp, `LCD_RESP_OKAY);
		wait_idle(st);
		check_status("status after re-init", st, make_status(0, 1, 0, 8'h00, xfer_exp));
		expect_init(cfg);
	endtask

	initial begin
		#(WATCHDOG_NS);
		fail_now($sformatf("watchdog expired at %0t ns before the tests finished", $time));
	end

	initial begin
		awaddr     = '0;
		awvalid    = 1'b0;
		wdata      = '0;
		wvalid     = 1'b0;
		bready     = 1'b0;
		araddr     = '0;
		arvalid    = 1'b0;
		rready     = 1'b0;
		lcd_rdata  = 8'h00;
		lfsr_state = 32'hd5e4_ac6a;
		rd_expect  = 8'h00;
		xfer_exp   = 8'h00;
		e_prev     = 1'b0;
		@(posedge arst_n);
		powerup_reject_test();
		init_sequence_test();
		cmd_write_test();
		busy_reject_test();
		read_cycle_test();
		backpressure_test();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int PERIOD_NS    = 20,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1; // released away from the rising edge
	end

endmodule

//--- src/lcd_ctrl_top.sv
`timescale 1ns/1ns

module lcd_ctrl_top
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	output logic        e,
	output logic        rs,
	output logic        rw,
	output logic [7:0]  lcd_data,
	input  logic [7:0]  lcd_rdata
);

	logic        busy;
	logic        init_done;
	logic        cycle_done;
	logic        cfg_start;
	logic        cmd_start;
	logic        status_rd;
	lcd_reg_u    cfg_word;
	lcd_reg_u    cmd_word;
	lcd_status_t status;

	lcd_axil_decode u_decode (
		.clk(clk), .arst_n(arst_n),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .init_done(init_done), .status(status),
		.cfg_start(cfg_start), .cfg_word(cfg_word),
		.cmd_start(cmd_start), .cmd_word(cmd_word), .status_rd(status_rd)
	);

	lcd_bus_exec u_exec (
		.clk(clk), .arst_n(arst_n),
		.cfg_start(cfg_start), .cfg_word(cfg_word),
		.cmd_start(cmd_start), .cmd_word(cmd_word),
		.busy(busy), .init_done(init_done), .cycle_done(cycle_done),
		.e(e), .rs(rs), .rw(rw), .lcd_data(lcd_data)
	);

	lcd_result u_result (
		.clk(clk), .arst_n(arst_n),
		.busy(busy), .init_done(init_done), .cycle_done(cycle_done),
		.e(e), .rw(rw), .lcd_rdata(lcd_rdata),
		.status_rd(status_rd), .status(status)
	);

endmodule

//--- src/lcd_result.sv
`timescale 1ns/1ns

module lcd_result
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        busy,
	input  logic        init_done,
	input  logic        cycle_done,
	input  logic        e,
	input  logic        rw,
	input  logic [7:0]  lcd_rdata,
	input  logic        status_rd,
	output lcd_status_t status
);

	logic       e_q;
	logic       e_fall;
	logic       rd_valid;
	logic [7:0] rd_byte;
	logic [7:0] xfer_count;

	assign e_fall = e_q && !e; // seen on the clock after e drops

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			e_q        <= 1'b0;
			rd_valid   <= 1'b0;
			xfer_count <= 8'h00;
		end else begin
			e_q <= e;
			if (e_fall && rw)
				rd_valid <= 1'b1;
			else if (status_rd)
				rd_valid <= 1'b0; // cleared once software has seen it
			if (cycle_done)
				xfer_count <= xfer_count + 8'h01; // wraps at 255
		end
	end

	always_ff @(posedge clk) begin
		if (e_fall && rw)
			rd_byte <= lcd_rdata;
	end

	always_comb begin
		status            = '0;
		status.busy       = busy;
		status.init_done  = init_done;
		status.rd_valid   = rd_valid;
		status.rd_byte    = rd_byte;
		status.xfer_count = xfer_count;
	end

endmodule

//--- src/lcd_bus_exec.sv
`timescale 1ns/1ns
`include "lcd_defs.svh"

module lcd_bus_exec
	import lcd_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       cfg_start,
	input  lcd_reg_u   cfg_word,
	input  logic       cmd_start,
	input  lcd_reg_u   cmd_word,
	output logic       busy,
	output logic       init_done,
	output logic       cycle_done,
	output logic       e,
	output logic       rs,
	output logic       rw,
	output logic [7:0] lcd_data
);

	localparam int T           = `LCD_TICKS_PER_US;
	localparam int POWERUP_LEN = `LCD_POWERUP_US * T;
	localparam int FS_END      = `LCD_CMD_US * T;
	localparam int DC_BEG      = FS_END + `LCD_GAP_US * T;
	localparam int DC_END      = DC_BEG + `LCD_CMD_US * T;
	localparam int CLR_BEG     = DC_END + `LCD_GAP_US * T;
	localparam int CLR_END     = CLR_BEG + `LCD_CMD_US * T;
	localparam int ENT_BEG     = CLR_END + `LCD_CLEAR_GAP_US * T;
	localparam int ENT_END     = ENT_BEG + `LCD_CMD_US * T;
	localparam int INIT_LEN    = ENT_END + `LCD_ENTRY_GAP_US * T;
	localparam int CYCLE_LEN   = `LCD_CYCLE_US * T;
	localparam int E_RISE      = `LCD_E_SETUP_US * T;
	localparam int E_FALL      = `LCD_E_HIGH_END_US * T;
	localparam int BUS_END     = `LCD_E_LOW_END_US * T;
	localparam int CNT_W       = $clog2(POWERUP_LEN + 1); // power-up is the longest phase

	lcd_state_e       state;
	logic [CNT_W-1:0] cnt; // single phase timer cleared at every boundary
	logic             phase_end;

	always_comb begin
		case (state)
			st_powerup: phase_end = (cnt == POWERUP_LEN - 1);
			st_init:    phase_end = (cnt == INIT_LEN - 1);
			st_cycle:   phase_end = (cnt == CYCLE_LEN - 1);
			default:    phase_end = 1'b0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_powerup;
			cnt   <= '0;
		end else begin
			if (phase_end || state == st_wait_cfg || state == st_idle)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			case (state)
				st_powerup: if (phase_end) state <= st_wait_cfg;
				st_wait_cfg: if (cfg_start) state <= st_init;
				st_init: if (phase_end) state <= st_idle;
				st_idle: begin
					if (cfg_start)
						state <= st_init; // re-run init with new fields
					else if (cmd_start)
						state <= st_cycle;
				end
				st_cycle: if (phase_end) state <= st_idle;
				default: state <= st_powerup;
			endcase
		end
	end

	assign busy       = (state == st_powerup) || (state == st_init) || (state == st_cycle);
	assign init_done  = (state == st_idle) || (state == st_cycle);
	assign cycle_done = (state == st_cycle) && phase_end;

	// init bytes stay one clock past the e fall for hold time
	always_comb begin
		e        = 1'b0;
		rs       = 1'b0;
		rw       = 1'b0;
		lcd_data = 8'h00;
		case (state)
			st_init: begin
				if (cnt <= FS_END) begin
					e        = (cnt < FS_END);
					lcd_data = {4'b0011, cfg_word.cfg.n, cfg_word.cfg.f, 2'b00}; // function set
				end else if (cnt >= DC_BEG && cnt <= DC_END) begin
					e        = (cnt < DC_END);
					lcd_data = {5'b00001, cfg_word.cfg.d, cfg_word.cfg.c, cfg_word.cfg.b};
				end else if (cnt >= CLR_BEG && cnt <= CLR_END) begin
					e        = (cnt < CLR_END);
					lcd_data = 8'h01; // clear display
				end else if (cnt >= ENT_BEG && cnt <= ENT_END) begin
					e        = (cnt < ENT_END);
					lcd_data = {6'b000001, cfg_word.cfg.id, cfg_word.cfg.s}; // entry mode
				end
			end
			st_cycle: begin
				e = (cnt >= E_RISE) && (cnt < E_FALL); // positive half-cycle
				if (cnt < BUS_END) begin // lines released after the negative half-cycle
					rs       = cmd_word.cmd.rs;
					rw       = cmd_word.cmd.rw;
					lcd_data = cmd_word.cmd.data;
				end
			end
			default: ;
		endcase
	end

	// panel lines hold still for as long as e stays high
	a_lines_hold_with_e: assert property (@(posedge clk) disable iff (!arst_n)
		e && $past(e) |-> $stable(rs) && $stable(rw) && $stable(lcd_data));

	// decode filters writes on busy so no start may land mid-phase
	a_no_start_busy: assert property (@(posedge clk) disable iff (!arst_n)
		(cfg_start || cmd_start) |-> !busy);

endmodule

//--- src/lcd_axil_decode.sv
`timescale 1ns/1ns
`include "lcd_defs.svh"

module lcd_axil_decode
	import lcd_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        busy,
	input  logic        init_done,
	input  lcd_status_t status,
	output logic        cfg_start,
	output lcd_reg_u    cfg_word,
	output logic        cmd_start,
	output lcd_reg_u    cmd_word,
	output logic        status_rd
);

	logic        aw_rdy; // shared by the aw and w channels
	logic        wr_go;
	logic        rd_go;
	logic        wr_cfg_ok;
	logic        wr_cmd_ok;
	logic [1:0]  wr_resp;
	logic [1:0]  rd_resp;
	logic [31:0] rd_word;

	assign awready = aw_rdy;
	assign wready  = aw_rdy;
	assign wr_go   = awvalid && wvalid && aw_rdy;
	assign rd_go   = arvalid && arready;

	always_comb begin
		wr_cfg_ok = 1'b0;
		wr_cmd_ok = 1'b0;
		wr_resp   = `LCD_RESP_SLVERR;
		case (awaddr)
			`LCD_ADDR_CFG: begin
				if (!busy) begin
					wr_cfg_ok = 1'b1;
					wr_resp   = `LCD_RESP_OKAY;
				end
			end
			`LCD_ADDR_CMD: begin
				if (!busy && init_done) begin
					wr_cmd_ok = 1'b1;
					wr_resp   = `LCD_RESP_OKAY;
				end
			end
			`LCD_ADDR_STATUS: wr_resp = `LCD_RESP_OKAY; // read-only, write dropped
			default: ;
		endcase
	end

	always_comb begin
		rd_resp = `LCD_RESP_OKAY;
		rd_word = '0;
		case (araddr)
			`LCD_ADDR_CFG: rd_word = cfg_word;
			`LCD_ADDR_CMD: rd_word = cmd_word;
			`LCD_ADDR_STATUS: rd_word = status;
			default: rd_resp = `LCD_RESP_SLVERR;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_rdy    <= 1'b0;
			bvalid    <= 1'b0;
			bresp     <= `LCD_RESP_OKAY;
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			rresp     <= `LCD_RESP_OKAY;
			cfg_start <= 1'b0;
			cmd_start <= 1'b0;
			status_rd <= 1'b0;
			cfg_word  <= `LCD_CFG_RESET;
		end else begin
			aw_rdy    <= awvalid && wvalid && !aw_rdy && !bvalid; // no accept while b is held
			arready   <= arvalid && !arready && !rvalid;
			cfg_start <= wr_go && wr_cfg_ok;
			cmd_start <= wr_go && wr_cmd_ok;
			status_rd <= rd_go && (araddr == `LCD_ADDR_STATUS);
			if (wr_go) begin
				bvalid <= 1'b1;
				bresp  <= wr_resp;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
			if (rd_go) begin
				rvalid <= 1'b1;
				rresp  <= rd_resp;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
			if (wr_go && wr_cfg_ok)
				cfg_word <= wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go && wr_cmd_ok)
			cmd_word <= wdata;
		if (rd_go)
			rdata <= rd_word;
	end

	// a stalled write response keeps its code until taken
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

//--- src/lcd_pkg.sv
package lcd_pkg;

	typedef struct packed {
		logic [24:0] unused;
		logic        n;  // two-line display
		logic        f;  // 5x10 font
		logic        d;  // display on
		logic        c;  // cursor on
		logic        b;  // cursor blink
		logic        id; // address increment
		logic        s;  // display shift
	} lcd_cfg_t;

	typedef struct packed {
		logic [21:0] unused;
		logic        rs;
		logic        rw;
		logic [7:0]  data;
	} lcd_cmd_t;

	// one bus word, seen as config or as command
	typedef union packed {
		lcd_cfg_t cfg;
		lcd_cmd_t cmd;
	} lcd_reg_u;

	typedef enum logic [2:0] {
		st_powerup,
		st_wait_cfg,
		st_init,
		st_idle,
		st_cycle
	} lcd_state_e;

	typedef struct packed {
		logic [7:0] unused_hi;
		logic [7:0] xfer_count;
		logic [7:0] rd_byte;
		logic [4:0] unused_lo;
		logic       rd_valid;
		logic       init_done;
		logic       busy;
	} lcd_status_t;

endpackage

//--- include/lcd_defs.svh
`ifndef LCD_DEFS_SVH
`define LCD_DEFS_SVH

// clocks per microsecond unit, kept small for simulation
`define LCD_TICKS_PER_US 2

`define LCD_POWERUP_US 500
`define LCD_CMD_US 10
`define LCD_GAP_US 50
`define LCD_CLEAR_GAP_US 200
`define LCD_ENTRY_GAP_US 100

`define LCD_CYCLE_US 50
`define LCD_E_SETUP_US 1
`define LCD_E_HIGH_END_US 14
`define LCD_E_LOW_END_US 27

`define LCD_ADDR_CFG 32'h0000_0000
`define LCD_ADDR_CMD 32'h0000_0004
`define LCD_ADDR_STATUS 32'h0000_0008

`define LCD_RESP_OKAY 2'b00
`define LCD_RESP_SLVERR 2'b10

`define LCD_CFG_RESET 32'h0000_0052 // n=1 f=0 d=1 c=0 b=0 id=1 s=0

`endif
